//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_execute
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- filelist.f
+incdir+verif
source/ex_pkg.sv
source/operand_select.sv
source/alu.sv
source/branch_resolve.sv
source/ex_mem_reg.sv
source/execute_stage.sv
verif/tb_execute.sv

//--- source/alu.sv
`timescale 1ns/1ns

module alu (
    input  ex_pkg::id_ex_t id_ex_i,
    input  ex_pkg::word_t  op_a_i,
    input  ex_pkg::word_t  op_b_i,
    output ex_pkg::word_t  result_o
);

    import ex_pkg::*;

    logic                is_sub;
    logic                is_arith;
    logic [SHAMT_W-1:0]  shamt;
    word_t               sum;
    word_t               sll_res;
    word_t               srl_res;
    word_t               sra_res;
    word_t               slt_res;
    word_t               sltu_res;
    word_t               logic_or;
    word_t               logic_xor;
    word_t               logic_and;
    word_t               reg_imm_res;

    // SUB only exists in the register form, ADDI has no funct7
    assign is_sub   = (id_ex_i.opcode == OP_REG) && (id_ex_i.funct7 == FUNCT7_ALT);
    assign is_arith = (id_ex_i.funct7 == FUNCT7_ALT);  // SRA and SRAI
    assign shamt    = op_b_i[SHAMT_W-1:0];

    assign sum       = is_sub ? (op_a_i - op_b_i) : (op_a_i + op_b_i);
    assign sll_res   = op_a_i << shamt;
    assign srl_res   = op_a_i >> shamt;
    assign sra_res   = word_t'($signed(op_a_i) >>> shamt);
    assign slt_res   = word_t'($signed(op_a_i) < $signed(op_b_i));
    assign sltu_res  = word_t'(op_a_i < op_b_i);
    assign logic_or  = op_a_i | op_b_i;
    assign logic_xor = op_a_i ^ op_b_i;
    assign logic_and = op_a_i & op_b_i;

    // Shared by OP_IMM and OP_REG
    always_comb begin
        case (alu_f3_e'(id_ex_i.funct3))
            F3_ADDSUB: reg_imm_res = sum;
            F3_SLL:    reg_imm_res = sll_res;
            F3_SLT:    reg_imm_res = slt_res;
            F3_SLTU:   reg_imm_res = sltu_res;
            F3_XOR:    reg_imm_res = logic_xor;
            F3_SRLSRA: reg_imm_res = is_arith ? sra_res : srl_res;
            F3_OR:     reg_imm_res = logic_or;
            F3_AND:    reg_imm_res = logic_and;
            default:   reg_imm_res = '0;
        endcase
    end

    always_comb begin
        case (id_ex_i.opcode)
            OP_LUI:    result_o = id_ex_i.imm;
            OP_AUIPC,
            OP_JAL,
            OP_BRANCH,                           // Branch target
            OP_LOAD,
            OP_STORE:  result_o = sum;           // Address or target
            OP_JALR:   result_o = {sum[XLEN-1:1], 1'b0};
            OP_IMM,
            OP_REG:    result_o = reg_imm_res;
            default:   result_o = '0;
        endcase
    end

endmodule

//--- source/branch_resolve.sv
`timescale 1ns/1ns

module branch_resolve (
    input  ex_pkg::id_ex_t      id_ex_i,
    input  ex_pkg::bpu_pred_t   bpu_pred_i,
    input  ex_pkg::word_t       rs1_val_i,
    input  ex_pkg::word_t       rs2_val_i,
    input  ex_pkg::word_t       target_i,
    output ex_pkg::redirect_t   redirect_o,
    output ex_pkg::bpu_update_t bpu_update_o
);

    import ex_pkg::*;

    logic  cond;
    logic  actual_taken;
    logic  any_jump;
    word_t pc_next;

    // Condition on the forwarded register values
    always_comb begin
        case (br_f3_e'(id_ex_i.funct3))
            F3_BEQ:  cond = (rs1_val_i == rs2_val_i);
            F3_BNE:  cond = (rs1_val_i != rs2_val_i);
            F3_BLT:  cond = ($signed(rs1_val_i) < $signed(rs2_val_i));
            F3_BGE:  cond = ($signed(rs1_val_i) >= $signed(rs2_val_i));
            F3_BLTU: cond = (rs1_val_i < rs2_val_i);
            F3_BGEU: cond = (rs1_val_i >= rs2_val_i);
            default: cond = 1'b0;
        endcase
    end

    assign actual_taken = (id_ex_i.branch_inst && cond) || id_ex_i.jal_inst
                          || id_ex_i.jalr_inst;
    assign any_jump     = id_ex_i.branch_inst || id_ex_i.jal_inst || id_ex_i.jalr_inst;
    assign pc_next      = id_ex_i.pc + INST_BYTES;

    // Compare the guess with the real outcome
    always_comb begin
        redirect_o.taken  = 1'b0;
        redirect_o.target = pc_next;
        case ({bpu_pred_i.taken, actual_taken})
            2'b01: begin
                redirect_o.taken  = 1'b1;
                redirect_o.target = target_i;
            end
            2'b10: begin
                redirect_o.taken  = 1'b1;                  // Fall through was right
            end
            2'b11: begin
                // Direct targets come from the BTB exactly, JALR can still miss
                if (id_ex_i.jalr_inst && (bpu_pred_i.target != target_i)) begin
                    redirect_o.taken  = 1'b1;
                    redirect_o.target = target_i;
                end
            end
            default: begin
                redirect_o.taken  = 1'b0;
            end
        endcase
    end

    always_comb begin
        bpu_update_o.pht_index = bpu_pred_i.pht_index;
        if (actual_taken) begin
            bpu_update_o.pht_data = (bpu_pred_i.pht_data == 2'b11) ?
                                    2'b11 : bpu_pred_i.pht_data + 2'd1;
        end else begin
            bpu_update_o.pht_data = (bpu_pred_i.pht_data == 2'b00) ?
                                    2'b00 : bpu_pred_i.pht_data - 2'd1;
        end
        bpu_update_o.pht_en   = id_ex_i.branch_inst;
        bpu_update_o.ghr_data = actual_taken;
        bpu_update_o.ghr_en   = id_ex_i.branch_inst;
        bpu_update_o.btb_addr = id_ex_i.pc;
        bpu_update_o.btb_data = {target_i[XLEN-1:2], bpu_pred_i.branch_type};
        bpu_update_o.btb_en   = !bpu_pred_i.btb_hit && any_jump;  // Allocate on miss only
    end

endmodule

//--- source/ex_mem_reg.sv
`timescale 1ns/1ns

module ex_mem_reg (
    input  logic                CLK,
    input  logic                RST,
    input  ex_pkg::id_ex_t      id_ex_i,
    input  logic                load_stall_i,
    input  ex_pkg::word_t       alu_result_i,
    input  ex_pkg::word_t       rs2_val_i,
    input  ex_pkg::redirect_t   redirect_i,
    input  ex_pkg::bpu_update_t bpu_update_i,
    output ex_pkg::ex_mem_t     ex_mem_o,
    output ex_pkg::bpu_update_t bpu_update_o
);

    import ex_pkg::*;

    ex_mem_t entry_d;
    word_t   rd_data;
    logic    bubble;

    // Link address for jumps, nothing for branch and store
    always_comb begin
        case (id_ex_i.opcode)
            OP_JAL,
            OP_JALR:   rd_data = id_ex_i.pc + INST_BYTES;
            OP_BRANCH,
            OP_STORE:  rd_data = '0;
            default:   rd_data = alu_result_i;
        endcase
    end

    always_comb begin
        entry_d.alu_result    = alu_result_i;
        entry_d.rd_data       = rd_data;
        entry_d.store_data    = rs2_val_i;     // Forwarded rs2
        entry_d.rd_addr       = id_ex_i.rd_addr;
        entry_d.reg_write     = id_ex_i.reg_write;
        entry_d.load_store_op = id_ex_i.load_store_op;
        entry_d.redirect      = redirect_i;
    end

    // The instruction behind a redirect is on the wrong path
    assign bubble = load_stall_i || ex_mem_o.redirect.taken;

    always_ff @(posedge CLK) begin
        if (RST || bubble) begin
            ex_mem_o     <= '0;
            bpu_update_o <= '0;
        end else begin
            ex_mem_o     <= entry_d;
            bpu_update_o <= bpu_update_i;
        end
    end

endmodule

//--- source/ex_pkg.sv
package ex_pkg;

    localparam int unsigned XLEN       = 32;  // Data and address width
    localparam int unsigned SHAMT_W    = 5;   // Shift amount width
    localparam int unsigned PHT_IDX_W  = 11;  // PHT index width
    localparam int unsigned REG_ADDR_W = 5;   // Register file address width
    localparam int unsigned LSU_OP_W   = 5;   // Load/store operation code width

    typedef logic [XLEN-1:0] word_t;

    localparam word_t      INST_BYTES = 'd4;        // PC step to the next instruction
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // Selects SUB and SRA

    // RV32I major opcodes handled by this stage
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADDSUB = 3'b000,
        F3_SLL    = 3'b001,
        F3_SLT    = 3'b010,
        F3_SLTU   = 3'b011,
        F3_XOR    = 3'b100,
        F3_SRLSRA = 3'b101,
        F3_OR     = 3'b110,
        F3_AND    = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } br_f3_e;

    typedef enum logic [1:0] {
        SRC_RS  = 2'b00,
        SRC_PC  = 2'b01,
        SRC_IMM = 2'b10   // 2'b11 selects zero
    } src_sel_e;

    // Decoded instruction from the ID/EX register
    typedef struct packed {
        word_t                 pc;
        opcode_e               opcode;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        word_t                 rs1_data;
        word_t                 rs2_data;
        word_t                 imm;
        src_sel_e              src1_sel;
        src_sel_e              src2_sel;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  reg_write;
        logic [LSU_OP_W-1:0]   load_store_op;
        logic                  branch_inst;  // Conditional branch
        logic                  jal_inst;
        logic                  jalr_inst;
    } id_ex_t;

    // Forwarding controls and bypass data from the later stages
    typedef struct packed {
        logic  rs1_mem;
        logic  rs1_wb;
        logic  rs2_mem;
        logic  rs2_wb;
        word_t mem_data;   // RD data held in EX/MEM
        word_t wb_data;    // RD data held in MEM/WB
    } fwd_t;

    // Prediction made at fetch, carried down with the instruction
    typedef struct packed {
        logic                 taken;
        word_t                target;
        logic [PHT_IDX_W-1:0] pht_index;
        logic [1:0]           pht_data;
        logic                 btb_hit;
        logic [1:0]           branch_type;
    } bpu_pred_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic [PHT_IDX_W-1:0] pht_index;
        logic [1:0]           pht_data;
        logic                 pht_en;
        logic                 ghr_data;
        logic                 ghr_en;
        word_t                btb_addr;
        word_t                btb_data;
        logic                 btb_en;
    } bpu_update_t;

    typedef struct packed {
        word_t                 alu_result;
        word_t                 rd_data;
        word_t                 store_data;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  reg_write;
        logic [LSU_OP_W-1:0]   load_store_op;
        redirect_t             redirect;
    } ex_mem_t;

endpackage

//--- source/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic                CLK,
    input  logic                RST,
    input  ex_pkg::id_ex_t      id_ex_i,
    input  ex_pkg::fwd_t        fwd_i,
    input  ex_pkg::bpu_pred_t   bpu_pred_i,
    input  logic                load_stall_i,
    output ex_pkg::ex_mem_t     ex_mem_o,
    output ex_pkg::bpu_update_t bpu_update_o
);

    import ex_pkg::*;

    word_t       rs1_val;
    word_t       rs2_val;
    word_t       op_a;
    word_t       op_b;
    word_t       alu_result;
    redirect_t   redirect;
    bpu_update_t bpu_update;

    operand_select u_operand_select (
        .id_ex_i   (id_ex_i),
        .fwd_i     (fwd_i),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val),
        .op_a_o    (op_a),
        .op_b_o    (op_b)
    );

    alu u_alu (
        .id_ex_i  (id_ex_i),
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .result_o (alu_result)
    );

    // ALU sum doubles as the branch and jump target
    branch_resolve u_branch_resolve (
        .id_ex_i      (id_ex_i),
        .bpu_pred_i   (bpu_pred_i),
        .rs1_val_i    (rs1_val),
        .rs2_val_i    (rs2_val),
        .target_i     (alu_result),
        .redirect_o   (redirect),
        .bpu_update_o (bpu_update)
    );

    ex_mem_reg u_ex_mem_reg (
        .CLK          (CLK),
        .RST          (RST),
        .id_ex_i      (id_ex_i),
        .load_stall_i (load_stall_i),
        .alu_result_i (alu_result),
        .rs2_val_i    (rs2_val),
        .redirect_i   (redirect),
        .bpu_update_i (bpu_update),
        .ex_mem_o     (ex_mem_o),
        .bpu_update_o (bpu_update_o)
    );

endmodule

//--- source/operand_select.sv
`timescale 1ns/1ns

module operand_select (
    input  ex_pkg::id_ex_t id_ex_i,
    input  ex_pkg::fwd_t   fwd_i,
    output ex_pkg::word_t  rs1_val_o,
    output ex_pkg::word_t  rs2_val_o,
    output ex_pkg::word_t  op_a_o,
    output ex_pkg::word_t  op_b_o
);

    import ex_pkg::*;

    // MEM bypass beats WB bypass, which beats the register file
    function automatic word_t fwd_pick(
        input logic  mem_hit,
        input logic  wb_hit,
        input word_t mem_data,
        input word_t wb_data,
        input word_t rf_data
    );
        word_t val;
        if (mem_hit) begin
            val = mem_data;
        end else if (wb_hit) begin
            val = wb_data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    function automatic word_t src_pick(
        input src_sel_e sel,
        input word_t    rs_val,
        input word_t    pc,
        input word_t    imm
    );
        word_t val;
        case (sel)
            SRC_RS:  val = rs_val;
            SRC_PC:  val = pc;
            SRC_IMM: val = imm;
            default: val = '0;       // Unused select reads as zero
        endcase
        return val;
    endfunction

    word_t rs1_fwd;
    word_t rs2_fwd;

    always_comb begin
        rs1_fwd = fwd_pick(fwd_i.rs1_mem, fwd_i.rs1_wb, fwd_i.mem_data,
                           fwd_i.wb_data, id_ex_i.rs1_data);
        rs2_fwd = fwd_pick(fwd_i.rs2_mem, fwd_i.rs2_wb, fwd_i.mem_data,
                           fwd_i.wb_data, id_ex_i.rs2_data);
    end

    assign rs1_val_o = rs1_fwd;      // Also feeds branch compare
    assign rs2_val_o = rs2_fwd;      // Also feeds store data

    assign op_a_o = src_pick(id_ex_i.src1_sel, rs1_fwd, id_ex_i.pc, id_ex_i.imm);
    assign op_b_o = src_pick(id_ex_i.src2_sel, rs2_fwd, id_ex_i.pc, id_ex_i.imm);

endmodule

//--- verif/tb_ref.svh
// Register value after bypass with MEM over WB over the register file
function automatic word_t fwd_value(input logic mem_hit, input logic wb_hit,
                                    input fwd_t fwd, input word_t rf_data);
    word_t v;
    v = mem_hit ? fwd.mem_data : (wb_hit ? fwd.wb_data : rf_data);
    return v;
endfunction

function automatic word_t alu_operand(input src_sel_e sel, input word_t rs_val,
                                      input id_ex_t id);
    word_t v;
    case (sel)
        SRC_RS:  v = rs_val;
        SRC_PC:  v = id.pc;
        SRC_IMM: v = id.imm;
        default: v = '0;           // Fourth select value
    endcase
    return v;
endfunction

function automatic word_t ref_alu(input id_ex_t id, input fwd_t fwd);
    word_t a;
    word_t b;
    word_t r;
    a = alu_operand(id.src1_sel, fwd_value(fwd.rs1_mem, fwd.rs1_wb, fwd, id.rs1_data), id);
    b = alu_operand(id.src2_sel, fwd_value(fwd.rs2_mem, fwd.rs2_wb, fwd, id.rs2_data), id);
    r = '0;
    case (id.opcode)
        OP_LUI:    r = id.imm;
        OP_AUIPC, OP_JAL, OP_BRANCH, OP_LOAD, OP_STORE: r = a + b;
        OP_JALR:   r = (a + b) & ~32'h1;
        OP_IMM, OP_REG: begin
            case (id.funct3)
                3'd0: r = (id.opcode == OP_REG && id.funct7 == FUNCT7_ALT) ? a - b : a + b;
                3'd1: r = a << b[SHAMT_W-1:0];
                3'd2: r = {31'd0, $signed(a) < $signed(b)};
                3'd3: r = {31'd0, a < b};
                3'd4: r = a ^ b;
                3'd5: begin
                    if (id.funct7 == FUNCT7_ALT) r = $signed(a) >>> b[SHAMT_W-1:0];
                    else r = a >> b[SHAMT_W-1:0];
                end
                3'd6: r = a | b;
                3'd7: r = a & b;
            endcase
        end
        default:   r = '0;
    endcase
    return r;
endfunction

// Real direction of a branch or jump
function automatic logic branch_outcome(input id_ex_t id, input fwd_t fwd);
    word_t x;
    word_t y;
    logic  c;
    x = fwd_value(fwd.rs1_mem, fwd.rs1_wb, fwd, id.rs1_data);
    y = fwd_value(fwd.rs2_mem, fwd.rs2_wb, fwd, id.rs2_data);
    case (id.funct3)
        3'd0:    c = (x == y);
        3'd1:    c = (x != y);
        3'd4:    c = ($signed(x) < $signed(y));
        3'd5:    c = ($signed(x) >= $signed(y));
        3'd6:    c = (x < y);
        3'd7:    c = (x >= y);
        default: c = 1'b0;
    endcase
    return (id.branch_inst && c) || id.jal_inst || id.jalr_inst;
endfunction

function automatic redirect_t ref_redirect(input id_ex_t id, input fwd_t fwd,
                                           input bpu_pred_t pred);
    redirect_t rd;
    logic      act;
    act       = branch_outcome(id, fwd);
    rd.taken  = (pred.taken != act) ||
                (pred.taken && act && id.jalr_inst && pred.target != ref_alu(id, fwd));
    rd.target = (act && rd.taken) ? ref_alu(id, fwd) : id.pc + INST_BYTES;
    return rd;
endfunction

function automatic bpu_update_t ref_bpu_update(input id_ex_t id, input fwd_t fwd,
                                               input bpu_pred_t pred);
    bpu_update_t u;
    logic        act;
    word_t       tgt;
    act         = branch_outcome(id, fwd);
    tgt         = ref_alu(id, fwd);
    u.pht_index = pred.pht_index;
    if (act) u.pht_data = (pred.pht_data == 2'b11) ? 2'b11 : pred.pht_data + 2'b01;
    else u.pht_data = (pred.pht_data == 2'b00) ? 2'b00 : pred.pht_data - 2'b01;
    u.pht_en    = id.branch_inst;
    u.ghr_data  = act;
    u.ghr_en    = id.branch_inst;
    u.btb_addr  = id.pc;
    u.btb_data  = {tgt[XLEN-1:2], pred.branch_type};   // Target word plus type
    u.btb_en    = !pred.btb_hit && (id.branch_inst || id.jal_inst || id.jalr_inst);
    return u;
endfunction

function automatic word_t ref_rd_data(input id_ex_t id, input word_t alu_res);
    word_t v;
    case (id.opcode)
        OP_JAL, OP_JALR:     v = id.pc + INST_BYTES;  // Link address
        OP_BRANCH, OP_STORE: v = '0;
        default:             v = alu_res;
    endcase
    return v;
endfunction

//--- verif/tb_execute.sv
`timescale 1ns/1ns

module tb_execute;

    import ex_pkg::*;

    localparam int NUM_VEC     = 250 + 80 + 256 + 60;  // Random, bypass, branch, stall
    localparam int CYCLE_LIMIT = 16 + 4 * NUM_VEC;

    logic        CLK;
    logic        RST;
    id_ex_t      id_ex_i;
    fwd_t        fwd_i;
    bpu_pred_t   bpu_pred_i;
    logic        load_stall_i;
    ex_mem_t     ex_mem_o;
    bpu_update_t bpu_update_o;

    ex_mem_t     exp_ex;
    bpu_update_t exp_bpu;
    logic [31:0] rng_state = 32'd1;   // Seed
    int          cycles    = 0;
    int          errors    = 0;

    `include "tb_ref.svh"

    execute_stage uut (
        .CLK          (CLK),
        .RST          (RST),
        .id_ex_i      (id_ex_i),
        .fwd_i        (fwd_i),
        .bpu_pred_i   (bpu_pred_i),
        .load_stall_i (load_stall_i),
        .ex_mem_o     (ex_mem_o),
        .bpu_update_o (bpu_update_o)
    );

    function logic [31:0] rand32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic fail_value(input string name, input word_t got, input word_t exp);
        $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
        errors++;
        $display("tests failed");
        $fatal(1, "stopped at first mismatch, time %0t", $time);
    endtask

    task automatic check_ex_mem(input ex_mem_t g, input ex_mem_t e);
        if (g.alu_result !== e.alu_result)
            fail_value("ex_mem_o.alu_result", g.alu_result, e.alu_result);
        if (g.rd_data !== e.rd_data)
            fail_value("ex_mem_o.rd_data", g.rd_data, e.rd_data);
        if (g.store_data !== e.store_data)
            fail_value("ex_mem_o.store_data", g.store_data, e.store_data);
        if (g.rd_addr !== e.rd_addr)
            fail_value("ex_mem_o.rd_addr", word_t'(g.rd_addr), word_t'(e.rd_addr));
        if (g.reg_write !== e.reg_write)
            fail_value("ex_mem_o.reg_write", word_t'(g.reg_write), word_t'(e.reg_write));
        if (g.load_store_op !== e.load_store_op)
            fail_value("ex_mem_o.load_store_op", word_t'(g.load_store_op),
                       word_t'(e.load_store_op));
        if (g.redirect.taken !== e.redirect.taken)
            fail_value("ex_mem_o.redirect.taken", word_t'(g.redirect.taken),
                       word_t'(e.redirect.taken));
        if (g.redirect.target !== e.redirect.target)
            fail_value("ex_mem_o.redirect.target", g.redirect.target, e.redirect.target);
    endtask

    task automatic check_bpu(input bpu_update_t g, input bpu_update_t e);
        if (g.pht_index !== e.pht_index)
            fail_value("bpu_update_o.pht_index", word_t'(g.pht_index), word_t'(e.pht_index));
        if (g.pht_data !== e.pht_data)
            fail_value("bpu_update_o.pht_data", word_t'(g.pht_data), word_t'(e.pht_data));
        if (g.pht_en !== e.pht_en)
            fail_value("bpu_update_o.pht_en", word_t'(g.pht_en), word_t'(e.pht_en));
        if (g.ghr_data !== e.ghr_data)
            fail_value("bpu_update_o.ghr_data", word_t'(g.ghr_data), word_t'(e.ghr_data));
        if (g.ghr_en !== e.ghr_en)
            fail_value("bpu_update_o.ghr_en", word_t'(g.ghr_en), word_t'(e.ghr_en));
        if (g.btb_addr !== e.btb_addr)
            fail_value("bpu_update_o.btb_addr", g.btb_addr, e.btb_addr);
        if (g.btb_data !== e.btb_data)
            fail_value("bpu_update_o.btb_data", g.btb_data, e.btb_data);
        if (g.btb_en !== e.btb_en)
            fail_value("bpu_update_o.btb_en", word_t'(g.btb_en), word_t'(e.btb_en));
    endtask

    function automatic ex_mem_t ref_entry(input id_ex_t id, input fwd_t fwd,
                                          input bpu_pred_t pred);
        ex_mem_t e;
        e.alu_result    = ref_alu(id, fwd);
        e.rd_data       = ref_rd_data(id, e.alu_result);
        e.store_data    = fwd_value(fwd.rs2_mem, fwd.rs2_wb, fwd, id.rs2_data);
        e.rd_addr       = id.rd_addr;
        e.reg_write     = id.reg_write;
        e.load_store_op = id.load_store_op;
        e.redirect      = ref_redirect(id, fwd, pred);
        return e;
    endfunction

    // Kind 0..5 conditional branches, 6 JAL, 7 JALR, 8 up ALU, load and store
    task automatic drive_vector(input logic [3:0] kind, input logic pred, input logic tgt_ok,
                                input logic [1:0] pht, input logic use_fwd);
        id_ex_t      id;
        logic [31:0] r;
        r           = rand32();
        id          = '0;
        id.pc       = rand32() & ~32'h3;
        id.funct3   = r[2:0];
        id.funct7   = r[3] ? FUNCT7_ALT : 7'd0;
        id.rs1_data = rand32();
        id.rs2_data = r[4] ? id.rs1_data : rand32();  // Equal operands now and then
        id.imm      = rand32();
        id.rd_addr  = r[9:5];
        id.reg_write = 1'b1;
        id.src1_sel = SRC_RS;
        id.src2_sel = SRC_IMM;
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
                id.opcode      = OP_BRANCH;
                id.funct3      = (kind < 4'd2) ? kind[2:0] : kind[2:0] + 3'd2;
                id.branch_inst = 1'b1;
                id.reg_write   = 1'b0;
                id.src1_sel    = SRC_PC;
            end
            4'd6: begin
                id.opcode   = OP_JAL;
                id.jal_inst = 1'b1;
                id.src1_sel = SRC_PC;
            end
            4'd7: begin
                id.opcode    = OP_JALR;
                id.jalr_inst = 1'b1;
            end
            4'd8: begin
                id.opcode   = OP_REG;
                id.src2_sel = SRC_RS;
            end
            4'd9:  id.opcode = OP_IMM;
            4'd10: id.opcode = OP_LUI;
            4'd11: begin
                id.opcode   = OP_AUIPC;
                id.src1_sel = SRC_PC;
            end
            4'd12: begin
                id.opcode        = OP_LOAD;
                id.load_store_op = r[14:10];
            end
            default: begin
                id.opcode        = OP_STORE;
                id.load_store_op = r[14:10];
                id.reg_write     = 1'b0;
            end
        endcase
        id_ex_i        = id;
        fwd_i.rs1_mem  = use_fwd & r[15];
        fwd_i.rs1_wb   = use_fwd & r[16];
        fwd_i.rs2_mem  = use_fwd & r[17];
        fwd_i.rs2_wb   = use_fwd & r[18];
        fwd_i.mem_data = rand32();
        fwd_i.wb_data  = rand32();
        bpu_pred_i.taken       = pred;
        bpu_pred_i.target      = tgt_ok ? ref_alu(id, fwd_i) : ref_alu(id, fwd_i) ^ 32'h40;
        bpu_pred_i.pht_index   = r[29:19];
        bpu_pred_i.pht_data    = pht;
        bpu_pred_i.btb_hit     = pht[0];   // Every kind sees both hit and miss
        bpu_pred_i.branch_type = r[31:30];
    endtask

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // Expected entry trails the inputs by one edge
    initial begin
        exp_ex  = '0;
        exp_bpu = '0;
        forever begin
            @(posedge CLK);
            if (RST || load_stall_i || exp_ex.redirect.taken) begin
                exp_ex  = '0;
                exp_bpu = '0;
            end else begin
                exp_ex  = ref_entry(id_ex_i, fwd_i, bpu_pred_i);
                exp_bpu = ref_bpu_update(id_ex_i, fwd_i, bpu_pred_i);
            end
            @(negedge CLK);
            check_ex_mem(ex_mem_o, exp_ex);
            check_bpu(bpu_update_o, exp_bpu);
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        logic [31:0] r;
        RST          = 1'b1;
        load_stall_i = 1'b0;
        id_ex_i      = '0;
        fwd_i        = '0;
        bpu_pred_i   = '0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        for (int i = 0; i < 250; i++) begin
            @(negedge CLK);
            r = rand32();
            drive_vector({1'b1, r[2:0]}, 1'b0, 1'b1, r[4:3], 1'b0);  // ALU, load, store
        end
        for (int i = 0; i < 80; i++) begin
            @(negedge CLK);
            r = rand32();
            drive_vector(r[3:0], 1'b0, 1'b1, r[5:4], 1'b1);          // All bypass mixes
        end
        // Each kind against every guess and counter state
        for (int k = 0; k < 8; k++) begin
            for (int p = 0; p < 2; p++) begin
                for (int t = 0; t < 2; t++) begin
                    for (int s = 0; s < 4; s++) begin
                        @(negedge CLK);
                        drive_vector(k[3:0], p[0], t[0], s[1:0], 1'b0);
                        @(negedge CLK);
                        r = rand32();
                        drive_vector({1'b1, r[2:0]}, 1'b0, 1'b1, r[4:3], 1'b0);
                    end
                end
            end
        end
        for (int i = 0; i < 60; i++) begin
            @(negedge CLK);
            r = rand32();
            drive_vector(r[3:0], r[4], r[5], r[7:6], 1'b1);
            load_stall_i = (r[9:8] == 2'b00);
        end
        @(negedge CLK);
        load_stall_i = 1'b0;
        id_ex_i      = '0;
        fwd_i        = '0;
        bpu_pred_i   = '0;
        repeat (2) @(negedge CLK);
        @(posedge CLK);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
